// ==== gbCore.f ====
source/gbCorePkg.sv
source/gbMicrocodeRom.sv
source/gbDecode.sv
source/gbExecute.sv
source/gbRegisterFile.sv
source/gbCore.sv
verif/gbCoreBus_asserts.sv
verif/gbCoreTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the gbCore testbench with Verilator, runs it and scans the log
set -u
cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module gbCoreTb \
	--Mdir "$buildDir" \
	-f gbCore.f
buildStatus=$?
if [ "$buildStatus" -ne 0 ]; then
	echo "Verilator build failed with status $buildStatus"
	exit 1
fi

"./$buildDir/VgbCoreTb" 2>&1 | tee "$logFile"
runStatus=${PIPESTATUS[0]}
if [ "$runStatus" -ne 0 ]; then
	echo "Simulation exited with status $runStatus"
	exit 1
fi

if grep -q "Verification failed" "$logFile"; then
	echo "Failure reported in $logFile"
	exit 1
fi

echo "No failure reported in $logFile"
exit 0

// ==== source/gbCore.sv ====
`timescale 1ns/1ps

module gbCore
(
	input  logic iClock,
	input  logic rst,
	input  logic [7:0] readData,
	output logic [15:0] address,
	output logic readRequest,
	output logic writeEnable,
	output logic [7:0] writeData
);
	import gbCorePkg::*;

	microOp_t microOp;
	regSel_t operandSel;
	regSel_t regRead;
	regSel_t writeSel;
	logic incPc;
	logic flowEnable;
	logic [15:0] writeValue;
	logic regWrite;
	logic flagsWrite;
	logic [7:0] flagsValue;
	logic pcLoad;
	logic addrLoad;
	logic [15:0] regValue;
	logic [7:0] x8Value;
	logic [15:0] x16Value;
	logic [7:0] aValue;
	logic [7:0] flags;

	// --------------------
	// Sequencer, opcode comes straight off the read bus
	gbDecode decode0
	(
		.iClock(iClock),
		.rst(rst),
		.opcode(readData),
		.flags(flags),
		.microOp(microOp),
		.operandSel(operandSel),
		.incPc(incPc),
		.flowEnable(flowEnable)
	);

	gbExecute execute0
	(
		.microOp(microOp),
		.operandSel(operandSel),
		.flowEnable(flowEnable),
		.readData(readData),
		.regValue(regValue),
		.x8Value(x8Value),
		.x16Value(x16Value),
		.aValue(aValue),
		.regRead(regRead),
		.writeSel(writeSel),
		.writeValue(writeValue),
		.regWrite(regWrite),
		.flagsWrite(flagsWrite),
		.flagsValue(flagsValue),
		.pcLoad(pcLoad),
		.addrLoad(addrLoad),
		.readRequest(readRequest),
		.writeEnable(writeEnable),
		.writeData(writeData)
	);

	gbRegisterFile registers0
	(
		.iClock(iClock),
		.rst(rst),
		.regRead(regRead),
		.operandSel(operandSel),
		.writeSel(writeSel),
		.writeValue(writeValue),
		.regWrite(regWrite),
		.flagsWrite(flagsWrite),
		.pcLoad(pcLoad),
		.addrLoad(addrLoad),
		.incPc(incPc),
		.flowEnable(flowEnable),
		.flagsValue(flagsValue),
		.regValue(regValue),
		.x8Value(x8Value),
		.x16Value(x16Value),
		.aValue(aValue),
		.flags(flags),
		.address(address)
	);

endmodule

// ==== source/gbCorePkg.sv ====
package gbCorePkg;

	// --------------------
	// Sequencer states
	typedef enum logic [1:0]
	{
		afterReset,
		startFlow,
		runFlow,
		endFlow
	} flowState_t;

	// --------------------
	// Micro-operations
	typedef enum logic [4:0]
	{
		nop,
		setAddr,   // Latch the address select and start a read
		loadMem,   // Read data into a register
		memWrite,
		inc16,
		dec16,
		addX16,    // X16 plus the sign extended 8-bit operand
		setPc,
		jumpCb,    // Redirect to the CB flow of the byte just read
		storeX8,
		storeX16,
		loadX8,
		loadX16,
		aluOp,     // AND, XOR or LD r,r' picked from the opcode byte
		bitTest
	} microOp_t;

	// The first eight codes follow the register field of the opcode byte
	typedef enum logic [3:0]
	{
		regB = 4'd0,
		regC = 4'd1,
		regD = 4'd2,
		regE = 4'd3,
		regH = 4'd4,
		regL = 4'd5,
		regHl = 4'd6,
		regA = 4'd7,
		regPc = 4'd8,
		regSp = 4'd9,
		regX8 = 4'd10,
		regX16 = 4'd11,
		regDe = 4'd12,
		regNone = 4'd15
	} regSel_t;

	// Named after the branch they close, so endIfNotZero stops a JR NZ flow once Z is set
	typedef enum logic [1:0]
	{
		endNone,
		endAlways,
		endIfZero,
		endIfNotZero
	} endCond_t;

	localparam int flagZero = 7;
	localparam int flagNeg = 6;
	localparam logic [15:0] resetPc = 16'h0000;
	localparam int microAddrWidth = 8;

	// --------------------
	// Micro-flow entry points
	localparam logic [microAddrWidth-1:0] flowFetch = 8'd0;
	localparam logic [microAddrWidth-1:0] fetchDispatch = 8'd1;  // Opcode byte valid here
	localparam logic [microAddrWidth-1:0] flowNop = 8'd2;
	localparam logic [microAddrWidth-1:0] flowLdB = 8'd3;
	localparam logic [microAddrWidth-1:0] flowLdC = 8'd5;
	localparam logic [microAddrWidth-1:0] flowLdD = 8'd7;
	localparam logic [microAddrWidth-1:0] flowLdE = 8'd9;
	localparam logic [microAddrWidth-1:0] flowLdH = 8'd11;
	localparam logic [microAddrWidth-1:0] flowLdL = 8'd13;
	localparam logic [microAddrWidth-1:0] flowLdA = 8'd15;
	localparam logic [microAddrWidth-1:0] flowAlu = 8'd17;
	localparam logic [microAddrWidth-1:0] flowStHlA = 8'd18;
	localparam logic [microAddrWidth-1:0] flowLdAHl = 8'd20;
	localparam logic [microAddrWidth-1:0] flowIncHl = 8'd22;
	localparam logic [microAddrWidth-1:0] flowDecDe = 8'd23;
	localparam logic [microAddrWidth-1:0] flowJp = 8'd24;
	localparam logic [microAddrWidth-1:0] flowJrNz = 8'd29;
	localparam logic [microAddrWidth-1:0] flowCbPrefix = 8'd34;
	localparam logic [microAddrWidth-1:0] flowBit = 8'd36;

endpackage

// ==== source/gbDecode.sv ====
`timescale 1ns/1ps

module gbDecode
(
	input  logic iClock,
	input  logic rst,
	input  logic [7:0] opcode,
	input  logic [7:0] flags,
	output gbCorePkg::microOp_t microOp,
	output gbCorePkg::regSel_t operandSel,
	output logic incPc,
	output logic flowEnable
);
	import gbCorePkg::*;

	flowState_t state;
	flowState_t nextState;
	logic [microAddrWidth-1:0] microPc;
	logic [microAddrWidth-1:0] basicFlow;
	logic [microAddrWidth-1:0] cbFlow;
	endCond_t endCond;
	logic endHit;

	gbMicrocodeRom rom0
	(
		.microPc(microPc),
		.opcode(opcode),
		.microOp(microOp),
		.operandSel(operandSel),
		.incPc(incPc),
		.endCond(endCond),
		.basicFlow(basicFlow),
		.cbFlow(cbFlow)
	);

	assign flowEnable = (state == runFlow);

	always_comb
	begin
		case (endCond)
			endAlways: endHit = 1'b1;
			endIfZero: endHit = ~flags[flagZero];
			endIfNotZero: endHit = flags[flagZero];  // JR NZ not taken
			default: endHit = 1'b0;
		endcase
	end

	// --------------------
	// Flow state machine
	always_comb
	begin
		case (state)
			afterReset: nextState = startFlow;
			startFlow: nextState = runFlow;
			runFlow: nextState = endHit ? endFlow : runFlow;
			default: nextState = startFlow;  // endFlow always returns to fetch
		endcase
	end

	always_ff @(posedge iClock)
	begin
		if (rst)
			state <= afterReset;
		else
			state <= nextState;
	end

	// Micro-PC steps through a flow and jumps at the two dispatch points
	always_ff @(posedge iClock)
	begin
		if (rst || state == startFlow)
			microPc <= flowFetch;
		else if (flowEnable)
		begin
			if (microOp == jumpCb)
				microPc <= cbFlow;
			else if (microPc == fetchDispatch)
				microPc <= basicFlow;
			else
				microPc <= microPc + 8'd1;
		end
	end

endmodule

// ==== source/gbExecute.sv ====
`timescale 1ns/1ps

module gbExecute
(
	input  gbCorePkg::microOp_t microOp,
	input  gbCorePkg::regSel_t operandSel,
	input  logic flowEnable,
	input  logic [7:0] readData,
	input  logic [15:0] regValue,
	input  logic [7:0] x8Value,
	input  logic [15:0] x16Value,
	input  logic [7:0] aValue,
	output gbCorePkg::regSel_t regRead,
	output gbCorePkg::regSel_t writeSel,
	output logic [15:0] writeValue,
	output logic regWrite,
	output logic flagsWrite,
	output logic [7:0] flagsValue,
	output logic pcLoad,
	output logic addrLoad,
	output logic readRequest,
	output logic writeEnable,
	output logic [7:0] writeData
);
	import gbCorePkg::*;

	logic regWriteReq;
	logic flagsWriteReq;
	logic pcLoadReq;
	logic addrLoadReq;
	logic readReq;
	logic writeReq;
	logic zeroFlag;
	logic [7:0] aluResult;
	logic [7:0] bitMask;
	regSel_t srcField;
	regSel_t dstField;

	// The opcode byte stays on readData until the next read
	assign srcField = regSel_t'({1'b0, readData[2:0]});
	assign dstField = regSel_t'({1'b0, readData[5:3]});
	assign bitMask = 8'h01 << readData[5:3];
	assign aluResult = readData[3] ? (aValue ^ regValue[7:0]) : (aValue & regValue[7:0]);

	// --------------------
	// Operand select
	always_comb
	begin
		if (microOp == aluOp || microOp == bitTest)
			regRead = srcField;
		else
			regRead = operandSel;
	end

	// --------------------
	// Result and strobes
	always_comb
	begin
		writeSel = operandSel;
		writeValue = 16'h0000;
		regWriteReq = 1'b0;
		flagsWriteReq = 1'b0;
		pcLoadReq = 1'b0;
		addrLoadReq = 1'b0;
		readReq = 1'b0;
		writeReq = 1'b0;
		zeroFlag = 1'b0;
		case (microOp)
			setAddr:
			begin
				addrLoadReq = 1'b1;
				readReq = 1'b1;
			end
			loadMem:
			begin
				regWriteReq = 1'b1;
				// X16 takes its low byte from X8, which holds the earlier byte
				if (operandSel == regX16)
					writeValue = {readData, x8Value};
				else
					writeValue = {8'h00, readData};
			end
			memWrite: writeReq = 1'b1;
			inc16:
			begin
				writeValue = regValue + 16'd1;
				regWriteReq = 1'b1;
			end
			dec16:
			begin
				writeValue = regValue - 16'd1;
				regWriteReq = 1'b1;
			end
			addX16:
			begin
				writeSel = regX16;
				writeValue = x16Value + {{8{regValue[7]}}, regValue[7:0]};  // Signed offset
				regWriteReq = 1'b1;
			end
			setPc:
			begin
				writeValue = regValue;
				pcLoadReq = 1'b1;
			end
			storeX8:
			begin
				writeSel = regX8;
				writeValue = {8'h00, regValue[7:0]};
				regWriteReq = 1'b1;
			end
			storeX16:
			begin
				writeSel = regX16;
				writeValue = regValue;
				regWriteReq = 1'b1;
			end
			loadX8:
			begin
				writeValue = {8'h00, x8Value};
				regWriteReq = 1'b1;
			end
			loadX16:
			begin
				writeValue = x16Value;
				regWriteReq = 1'b1;
			end
			aluOp:
			begin
				regWriteReq = 1'b1;
				if (readData[7:6] == 2'b01)
				begin
					writeSel = dstField;  // LD r,r' leaves the flags alone
					writeValue = {8'h00, regValue[7:0]};
				end
				else
				begin
					writeSel = regA;
					writeValue = {8'h00, aluResult};
					flagsWriteReq = 1'b1;
					zeroFlag = (aluResult == 8'h00);
				end
			end
			bitTest:
			begin
				flagsWriteReq = 1'b1;
				zeroFlag = ((regValue[7:0] & bitMask) == 8'h00);
			end
			default:
			begin
				writeSel = operandSel;  // nop and jumpCb have no datapath effect
			end
		endcase
	end

	always_comb
	begin
		flagsValue = 8'h00;
		flagsValue[flagZero] = zeroFlag;
		flagsValue[flagNeg] = 1'b0;  // Only logic ops touch the flags
	end

	assign regWrite = regWriteReq & flowEnable;
	assign flagsWrite = flagsWriteReq & flowEnable;
	assign pcLoad = pcLoadReq & flowEnable;
	assign addrLoad = addrLoadReq & flowEnable;
	assign readRequest = readReq & flowEnable;
	assign writeEnable = writeReq & flowEnable;
	assign writeData = regValue[7:0];

endmodule

// ==== source/gbMicrocodeRom.sv ====
`timescale 1ns/1ps

module gbMicrocodeRom
(
	input  logic [gbCorePkg::microAddrWidth-1:0] microPc,
	input  logic [7:0] opcode,
	output gbCorePkg::microOp_t microOp,
	output gbCorePkg::regSel_t operandSel,
	output logic incPc,
	output gbCorePkg::endCond_t endCond,
	output logic [gbCorePkg::microAddrWidth-1:0] basicFlow,
	output logic [gbCorePkg::microAddrWidth-1:0] cbFlow
);
	import gbCorePkg::*;

	logic [11:0] romWord;  // {microOp, operandSel, incPc, endCond}

	assign microOp = microOp_t'(romWord[11:7]);
	assign operandSel = regSel_t'(romWord[6:3]);
	assign incPc = romWord[2];
	assign endCond = endCond_t'(romWord[1:0]);

	// --------------------
	// Micro-flows
	always_comb
	begin
		case (microPc)
			8'd0: romWord = {setAddr, regPc, 1'b1, endNone};   // Fetch
			8'd1: romWord = {nop, regNone, 1'b0, endNone};     // Dispatch on the opcode
			8'd2: romWord = {nop, regNone, 1'b0, endAlways};
			8'd3: romWord = {setAddr, regPc, 1'b1, endNone};
			8'd4: romWord = {loadMem, regB, 1'b0, endAlways};
			8'd5: romWord = {setAddr, regPc, 1'b1, endNone};
			8'd6: romWord = {loadMem, regC, 1'b0, endAlways};
			8'd7: romWord = {setAddr, regPc, 1'b1, endNone};
			8'd8: romWord = {loadMem, regD, 1'b0, endAlways};
			8'd9: romWord = {setAddr, regPc, 1'b1, endNone};
			8'd10: romWord = {loadMem, regE, 1'b0, endAlways};
			8'd11: romWord = {setAddr, regPc, 1'b1, endNone};
			8'd12: romWord = {loadMem, regH, 1'b0, endAlways};
			8'd13: romWord = {setAddr, regPc, 1'b1, endNone};
			8'd14: romWord = {loadMem, regL, 1'b0, endAlways};
			8'd15: romWord = {setAddr, regPc, 1'b1, endNone};
			8'd16: romWord = {loadMem, regA, 1'b0, endAlways};
			8'd17: romWord = {aluOp, regNone, 1'b0, endAlways};
			8'd18: romWord = {setAddr, regHl, 1'b0, endNone};
			8'd19: romWord = {memWrite, regA, 1'b0, endAlways};
			8'd20: romWord = {setAddr, regHl, 1'b0, endNone};
			8'd21: romWord = {loadMem, regA, 1'b0, endAlways};
			8'd22: romWord = {inc16, regHl, 1'b0, endAlways};
			8'd23: romWord = {dec16, regDe, 1'b0, endAlways};
			// JP a16 builds the target in X16, low byte first through X8
			8'd24: romWord = {setAddr, regPc, 1'b1, endNone};
			8'd25: romWord = {loadMem, regX8, 1'b0, endNone};
			8'd26: romWord = {setAddr, regPc, 1'b1, endNone};
			8'd27: romWord = {loadMem, regX16, 1'b0, endNone};
			8'd28: romWord = {setPc, regX16, 1'b0, endAlways};
			// JR NZ stops after the offset read when Z is set
			8'd29: romWord = {setAddr, regPc, 1'b1, endNone};
			8'd30: romWord = {loadMem, regX8, 1'b0, endIfNotZero};
			8'd31: romWord = {storeX16, regPc, 1'b0, endNone};
			8'd32: romWord = {addX16, regX8, 1'b0, endNone};
			8'd33: romWord = {setPc, regX16, 1'b0, endAlways};
			8'd34: romWord = {setAddr, regPc, 1'b1, endNone};  // Second opcode byte
			8'd35: romWord = {jumpCb, regNone, 1'b0, endNone};
			8'd36: romWord = {bitTest, regNone, 1'b0, endAlways};
			default: romWord = {nop, regNone, 1'b0, endAlways};
		endcase
	end

	// --------------------
	// Opcode lookup tables
	always_comb
	begin
		case (opcode)
			8'h06: basicFlow = flowLdB;
			8'h0E: basicFlow = flowLdC;
			8'h16: basicFlow = flowLdD;
			8'h1E: basicFlow = flowLdE;
			8'h26: basicFlow = flowLdH;
			8'h2E: basicFlow = flowLdL;
			8'h3E: basicFlow = flowLdA;
			8'h1B: basicFlow = flowDecDe;
			8'h20: basicFlow = flowJrNz;
			8'h23: basicFlow = flowIncHl;
			8'h77: basicFlow = flowStHlA;
			8'h7E: basicFlow = flowLdAHl;
			8'hC3: basicFlow = flowJp;
			8'hCB: basicFlow = flowCbPrefix;
			default:
			begin
				// Register moves, AND r and XOR r, but none of the (HL) forms
				if (opcode[7:6] == 2'b01 && opcode[5:3] != 3'd6 && opcode[2:0] != 3'd6)
					basicFlow = flowAlu;
				else if (opcode[7:4] == 4'hA && opcode[2:0] != 3'd6)
					basicFlow = flowAlu;
				else
					basicFlow = flowNop;
			end
		endcase
	end

	assign cbFlow = (opcode[7:6] == 2'b01 && opcode[2:0] != 3'd6) ? flowBit : flowNop;

endmodule

// ==== source/gbRegisterFile.sv ====
`timescale 1ns/1ps

module gbRegisterFile
(
	input  logic iClock,
	input  logic rst,
	input  gbCorePkg::regSel_t regRead,
	input  gbCorePkg::regSel_t operandSel,
	input  gbCorePkg::regSel_t writeSel,
	input  logic [15:0] writeValue,
	input  logic regWrite,
	input  logic flagsWrite,
	input  logic pcLoad,
	input  logic addrLoad,
	input  logic incPc,
	input  logic flowEnable,
	input  logic [7:0] flagsValue,
	output logic [15:0] regValue,
	output logic [7:0] x8Value,
	output logic [15:0] x16Value,
	output logic [7:0] aValue,
	output logic [7:0] flags,
	output logic [15:0] address
);
	import gbCorePkg::*;

	logic [7:0] bReg;
	logic [7:0] cReg;
	logic [7:0] dReg;
	logic [7:0] eReg;
	logic [7:0] hReg;
	logic [7:0] lReg;
	logic [7:0] aReg;
	logic [15:0] spReg;
	logic [7:0] x8Reg;
	logic [15:0] x16Reg;
	logic [7:0] flagsReg;
	logic [15:0] pcReg;
	regSel_t addrSel;
	regSel_t busSel;

	function automatic logic [15:0] readReg(input regSel_t sel);
		logic [15:0] value;
		case (sel)
			regB: value = {8'h00, bReg};
			regC: value = {8'h00, cReg};
			regD: value = {8'h00, dReg};
			regE: value = {8'h00, eReg};
			regH: value = {8'h00, hReg};
			regL: value = {8'h00, lReg};
			regHl: value = {hReg, lReg};
			regA: value = {8'h00, aReg};
			regPc: value = pcReg;
			regSp: value = spReg;
			regX8: value = {8'h00, x8Reg};
			regX16: value = x16Reg;
			regDe: value = {dReg, eReg};
			default: value = 16'h0000;
		endcase
		return value;
	endfunction

	// --------------------
	// Register writes
	always_ff @(posedge iClock)
	begin
		if (rst)
		begin
			bReg <= 8'h00;
			cReg <= 8'h00;
			dReg <= 8'h00;
			eReg <= 8'h00;
			hReg <= 8'h00;
			lReg <= 8'h00;
			aReg <= 8'h00;
			spReg <= 16'h0000;
			x8Reg <= 8'h00;
			x16Reg <= 16'h0000;
		end
		else if (regWrite)
		begin
			case (writeSel)
				regB: bReg <= writeValue[7:0];
				regC: cReg <= writeValue[7:0];
				regD: dReg <= writeValue[7:0];
				regE: eReg <= writeValue[7:0];
				regH: hReg <= writeValue[7:0];
				regL: lReg <= writeValue[7:0];
				regA: aReg <= writeValue[7:0];
				regHl: {hReg, lReg} <= writeValue;  // Pairs split high/low
				regDe: {dReg, eReg} <= writeValue;
				regSp: spReg <= writeValue;
				regX8: x8Reg <= writeValue[7:0];
				regX16: x16Reg <= writeValue;
				default: x8Reg <= x8Reg;
			endcase
		end
	end

	always_ff @(posedge iClock)
	begin
		if (rst)
			flagsReg <= 8'h00;
		else if (flagsWrite)
			flagsReg <= flagsValue;
	end

	// A jump load wins over the fetch increment
	always_ff @(posedge iClock)
	begin
		if (rst)
			pcReg <= resetPc;
		else if (pcLoad)
			pcReg <= writeValue;
		else if (incPc && flowEnable)
			pcReg <= pcReg + 16'd1;
	end

	always_ff @(posedge iClock)
	begin
		if (rst)
			addrSel <= regPc;
		else if (addrLoad)
			addrSel <= operandSel;
	end

	// The new select shows on the bus in the cycle it is latched
	assign busSel = addrLoad ? operandSel : addrSel;
	assign address = readReg(busSel);

	assign regValue = readReg(regRead);
	assign x8Value = x8Reg;
	assign x16Value = x16Reg;
	assign aValue = aReg;
	assign flags = flagsReg;

endmodule

// ==== verif/gbCoreBus_asserts.sv ====
`timescale 1ns/1ps

module gbCoreBusAsserts
(
	input logic iClock,
	input logic rst,
	input logic readRequest,
	input logic writeEnable
);

	// A read and a write never share a cycle
	readWriteExclusive: assert property (@(posedge iClock) !(readRequest && writeEnable))
		else $error("readRequest and writeEnable are high in the same cycle");

	// Reset is synchronous, so the bus goes quiet from the cycle after rst is seen
	quietInReset: assert property (@(posedge iClock) rst |=> (!readRequest && !writeEnable))
		else $error("Bus strobe is high while the core is held in reset");

	singleCycleWrite: assert property (@(posedge iClock) disable iff (rst)
		writeEnable |=> !writeEnable)
		else $error("writeEnable is high on two consecutive cycles");

endmodule

bind gbCore gbCoreBusAsserts busAsserts0
(
	.iClock(iClock),
	.rst(rst),
	.readRequest(readRequest),
	.writeEnable(writeEnable)
);

// ==== verif/gbCoreTb.sv ====
`timescale 1ns/1ps

module gbCoreTb;
	import gbCorePkg::*;

	logic iClock = 1'b0;
	logic rst = 1'b1;
	logic [7:0] readData = 8'h00;
	logic [15:0] address;
	logic readRequest;
	logic writeEnable;
	logic [7:0] writeData;

	logic [7:0] mem [0:255];
	logic [15:0] readAddrQ [$];
	logic [15:0] writeAddrQ [$];
	logic [7:0] writeDataQ [$];
	int readBase;
	int writeBase;
	logic [7:0] loadPtr;

	gbCore dut0
	(
		.iClock(iClock),
		.rst(rst),
		.readData(readData),
		.address(address),
		.readRequest(readRequest),
		.writeEnable(writeEnable),
		.writeData(writeData)
	);

	always #2 iClock = ~iClock;

	// Memory answers a read on the next edge and holds the byte until the next read
	always @(posedge iClock)
	begin
		if (readRequest)
		begin
			readData <= mem[address[7:0]];
			readAddrQ.push_back(address);
		end
		if (writeEnable)
		begin
			writeAddrQ.push_back(address);
			writeDataQ.push_back(writeData);
		end
	end

	// --------------------
	// Checking
	task automatic stopOnError(input string reason);
		$display("%s", reason);
		$display("Verification failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic compareByte(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		if (actual !== expected)
			stopOnError($sformatf("error at %0t: %s expected %h, got %h", $time, name,
				expected, actual));
	endtask

	task automatic compareAddr(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (actual !== expected)
			stopOnError($sformatf("error at %0t: %s expected %h, got %h", $time, name,
				expected, actual));
	endtask

	// Z is set by a zero result and N stays clear for logic ops and BIT
	function automatic logic [7:0] predictFlags(input logic [7:0] result);
		logic [7:0] f;
		f = 8'h00;
		f[flagZero] = (result == 8'h00);
		return f;
	endfunction

	// --------------------
	// Program loading and waits
	task automatic beginProgram();
		@(posedge iClock);
		rst <= 1'b1;
		for (int i = 0; i < 256; i++)
			mem[i] = 8'h00;  // NOP everywhere outside the program
		loadPtr = 8'h00;
	endtask

	task automatic releaseReset();
		repeat (4) @(posedge iClock);
		readBase = readAddrQ.size();
		writeBase = writeAddrQ.size();
		rst <= 1'b0;
	endtask

	task automatic emitByte(input logic [7:0] value);
		mem[loadPtr] = value;
		loadPtr = loadPtr + 8'd1;
	endtask

	task automatic haltHere();
		logic [7:0] here;
		here = loadPtr;
		emitByte(8'hC3);  // JP to itself
		emitByte(here);
		emitByte(8'h00);
	endtask

	task automatic waitReads(input int count, input int limit);
		int cycles;
		cycles = 0;
		while (readAddrQ.size() - readBase < count)
		begin
			if (cycles == limit)
				stopOnError($sformatf("Timed out after %0d cycles waiting for %0d reads",
					limit, count));
			else
			begin
				@(negedge iClock);
				cycles++;
			end
		end
	endtask

	task automatic waitWrites(input int count, input int limit);
		int cycles;
		cycles = 0;
		while (writeAddrQ.size() - writeBase < count)
		begin
			if (cycles == limit)
				stopOnError($sformatf("Timed out after %0d cycles waiting for %0d writes",
					limit, count));
			else
			begin
				@(negedge iClock);
				cycles++;
			end
		end
	endtask

	task automatic checkWrite(input int index, input logic [15:0] expAddr,
		input logic [7:0] expData);
		compareAddr($sformatf("address of write %0d", index), expAddr,
			writeAddrQ[writeBase + index]);
		compareByte($sformatf("writeData of write %0d", index), expData,
			writeDataQ[writeBase + index]);
	endtask

	// JR NZ over a store at fallLow, landing on a store at takenLow
	task automatic emitJrNzTail(input logic [7:0] fallLow, input logic [7:0] takenLow);
		emitByte(8'h26);
		emitByte(8'h00);
		emitByte(8'h2E);
		emitByte(fallLow);
		emitByte(8'h20);
		emitByte(8'h04);  // Skips the store and the halt
		emitByte(8'h77);
		haltHere();
		emitByte(8'h2E);
		emitByte(takenLow);
		emitByte(8'h77);
		haltHere();
	endtask

	task automatic checkBranch(input logic [7:0] flagsAfter, input logic [15:0] fallAddr,
		input logic [15:0] takenAddr, input logic [7:0] value);
		waitWrites(1, 300);
		if (flagsAfter[flagZero])
			checkWrite(0, fallAddr, value);
		else
			checkWrite(0, takenAddr, value);
	endtask

	// --------------------
	// Directed tests
	task automatic fetchAfterReset();
		beginProgram();  // All NOPs, so every read is a fetch
		releaseReset();
		waitReads(1, 4);
		compareAddr("address of first read", 16'h0000, readAddrQ[readBase]);
		waitReads(8, 100);
		for (int i = 1; i < 8; i++)
			compareAddr($sformatf("address of read %0d", i), 16'(i), readAddrQ[readBase + i]);
	endtask

	task automatic storeImmediate();
		logic [7:0] value;
		logic [7:0] low;
		value = 8'($urandom());
		low = 8'($urandom());
		beginProgram();
		emitByte(8'h3E);
		emitByte(value);
		emitByte(8'h26);
		emitByte(8'h00);
		emitByte(8'h2E);
		emitByte(low);
		emitByte(8'h77);
		haltHere();
		releaseReset();
		waitWrites(1, 200);
		checkWrite(0, {8'h00, low}, value);
	endtask

	task automatic logicAndMoves();
		logic [7:0] b;
		logic [7:0] c;
		logic [7:0] andResult;
		b = 8'($urandom());
		c = 8'($urandom());
		andResult = b & c;
		beginProgram();
		emitByte(8'h06);
		emitByte(b);
		emitByte(8'h0E);
		emitByte(c);
		emitByte(8'h78);  // LD A,B
		emitByte(8'hA1);  // AND C
		emitByte(8'h26);
		emitByte(8'h00);
		emitByte(8'h2E);
		emitByte(8'h80);
		emitByte(8'h77);
		emitByte(8'hA8);  // XOR B
		emitByte(8'h2E);
		emitByte(8'h81);
		emitByte(8'h77);
		emitByte(8'h41);  // C travels through B, D and E back into A
		emitByte(8'h3E);
		emitByte(8'h00);
		emitByte(8'h50);
		emitByte(8'h5A);
		emitByte(8'h7B);
		emitByte(8'h2E);
		emitByte(8'h82);
		emitByte(8'h77);
		haltHere();
		releaseReset();
		waitWrites(3, 400);
		checkWrite(0, 16'h0080, andResult);
		checkWrite(1, 16'h0081, andResult ^ b);
		checkWrite(2, 16'h0082, c);
	endtask

	task automatic copyAndPairOps();
		logic [7:0] data;
		logic [7:0] low;
		logic [7:0] d;
		logic [7:0] e;
		logic [15:0] de;
		data = 8'($urandom());
		low = 8'($urandom());
		d = 8'($urandom());
		e = 8'($urandom());
		de = {d, e} - 16'd1;
		beginProgram();
		emitByte(8'h26);
		emitByte(8'h00);
		emitByte(8'h2E);
		emitByte(8'hF0);
		emitByte(8'h7E);  // LD A,(HL)
		emitByte(8'h2E);
		emitByte(low);
		emitByte(8'h77);
		emitByte(8'h23);  // INC HL
		emitByte(8'h77);
		emitByte(8'h16);
		emitByte(d);
		emitByte(8'h1E);
		emitByte(e);
		emitByte(8'h1B);  // DEC DE
		emitByte(8'h26);
		emitByte(8'h00);
		emitByte(8'h2E);
		emitByte(8'hE0);
		emitByte(8'h7B);
		emitByte(8'h77);
		emitByte(8'h2E);
		emitByte(8'hE1);
		emitByte(8'h7A);
		emitByte(8'h77);
		haltHere();
		mem[8'hF0] = data;
		releaseReset();
		waitWrites(4, 500);
		checkWrite(0, {8'h00, low}, data);
		checkWrite(1, {8'h00, low} + 16'd1, data);
		checkWrite(2, 16'h00E0, de[7:0]);
		checkWrite(3, 16'h00E1, de[15:8]);
	endtask

	task automatic jumpAndBranch();
		logic [7:0] value;
		logic [7:0] target;
		logic [7:0] x;
		logic [7:0] y;
		value = 8'($urandom());
		beginProgram();
		emitByte(8'h3E);
		emitByte(value);
		emitByte(8'h26);
		emitByte(8'h00);
		emitByte(8'h2E);
		emitByte(8'hB0);
		target = loadPtr + 8'd4;  // Past the JP and the skipped store
		emitByte(8'hC3);
		emitByte(target);
		emitByte(8'h00);
		emitByte(8'h77);
		emitByte(8'h2E);
		emitByte(8'hB1);
		emitByte(8'h77);
		haltHere();
		releaseReset();
		waitWrites(1, 200);
		checkWrite(0, 16'h00B1, value);
		// Second round forces a zero XOR result
		for (int round = 0; round < 2; round++)
		begin
			x = 8'($urandom());
			y = (round == 0) ? 8'($urandom()) : x;
			beginProgram();
			emitByte(8'h3E);
			emitByte(x);
			emitByte(8'h06);
			emitByte(y);
			emitByte(8'hA8);
			emitJrNzTail(8'hC0, 8'hC1);
			releaseReset();
			checkBranch(predictFlags(x ^ y), 16'h00C0, 16'h00C1, x ^ y);
		end
	endtask

	task automatic bitAndBranch();
		logic [7:0] value;
		logic [2:0] bitIndex;
		value = 8'($urandom());
		bitIndex = 3'($urandom());
		beginProgram();
		emitByte(8'h3E);
		emitByte(value);
		emitByte(8'hCB);
		emitByte({2'b01, bitIndex, 3'b111});  // BIT b,A
		emitJrNzTail(8'hD0, 8'hD1);
		releaseReset();
		checkBranch(predictFlags({7'h00, value[bitIndex]}), 16'h00D0, 16'h00D1, value);
	endtask

	initial
	begin
		void'($urandom(32'hd175));
		readBase = 0;
		writeBase = 0;
		loadPtr = 8'h00;
		fetchAfterReset();
		storeImmediate();
		logicAndMoves();
		copyAndPairOps();
		jumpAndBranch();
		for (int i = 0; i < 6; i++)
			bitAndBranch();
		$display("Verification passed");
		$finish;
	end

endmodule
